//--- rtl/matmul_config.svh
`ifndef MATMUL_CONFIG_SVH
`define MATMUL_CONFIG_SVH

// word and counter widths
`define MATMUL_DATA_W 32
`define MATMUL_ADDR_W 12
`define MATMUL_DIM_W 7

// tile pairs in flight between producer and consumer
`define MATMUL_FIFO_DEPTH 4

// matrix regions in the shared memory, row-major
`define MATMUL_A_BASE 2
`define MATMUL_B_BASE 1026
`define MATMUL_C_BASE 2050

`endif

//--- rtl/matmul_tile_pkg.sv
`include "matmul_config.svh"

package matmul_tile_pkg;

    typedef logic [`MATMUL_DATA_W-1:0] data_t;

    // row, column or inner index, values up to 64
    typedef logic [`MATMUL_DIM_W-1:0] dim_t;

    // one bit per output element, bit 0 is upper-left and bit 3 lower-right
    typedef logic [3:0] tile_mask_t;

    typedef enum logic [2:0] {
        FETCH_IDLE,
        FETCH_ISSUE,
        FETCH_COLLECT,
        FETCH_PUSH,
        FETCH_DRAIN
    } fetch_state_e;

endpackage

//--- rtl/matmul_mem_pkg.sv
`include "matmul_config.svh"

package matmul_mem_pkg;

    typedef logic [`MATMUL_ADDR_W-1:0] addr_t;

    typedef enum logic [1:0] {
        REGION_A,
        REGION_B,
        REGION_C
    } mem_region_e;

    function automatic addr_t region_base(input mem_region_e region);
        case (region)
            REGION_A: return addr_t'(`MATMUL_A_BASE);
            REGION_B: return addr_t'(`MATMUL_B_BASE);
            default:  return addr_t'(`MATMUL_C_BASE);
        endcase
    endfunction

endpackage

//--- rtl/tile_fetch.sv
`include "matmul_config.svh"

module tile_fetch (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  matmul_tile_pkg::dim_t           rows,
    input  matmul_tile_pkg::dim_t           inner,
    input  matmul_tile_pkg::dim_t           cols,
    input  logic                            credit_return,
    input  logic                            done,
    input  matmul_tile_pkg::data_t          rd_data_a,
    input  matmul_tile_pkg::data_t          rd_data_b,
    output logic                            busy,
    output matmul_mem_pkg::addr_t           rd_addr_a,
    output matmul_mem_pkg::addr_t           rd_addr_b,
    output logic                            push,
    output matmul_tile_pkg::data_t [3:0]    a_tile,
    output matmul_tile_pkg::data_t [3:0]    b_tile,
    output matmul_tile_pkg::tile_mask_t     tile_mask,
    output matmul_mem_pkg::addr_t           result_addr,
    output logic                            last_step,
    output logic                            final_block
);
    localparam int CRED_W = $clog2(`MATMUL_FIFO_DEPTH + 1);
    localparam matmul_tile_pkg::dim_t ONE = 1;
    localparam matmul_tile_pkg::dim_t STEP = 2;

    matmul_tile_pkg::fetch_state_e state;
    matmul_tile_pkg::dim_t row0, col0, k0;
    matmul_tile_pkg::dim_t nxt_row, nxt_col, nxt_k;
    matmul_tile_pkg::dim_t i_row, i_col, i_k;
    matmul_mem_pkg::addr_t a_r, a_c, b_r, b_c;
    logic [1:0] rd_idx, i_idx, cap_idx;
    logic [CRED_W-1:0] credits;
    logic col_last, row_last, a_ok, b_ok;

    function automatic matmul_tile_pkg::tile_mask_t block_mask(
        input matmul_tile_pkg::dim_t r,
        input matmul_tile_pkg::dim_t c,
        input matmul_tile_pkg::dim_t nr,
        input matmul_tile_pkg::dim_t nc
    );
        logic r1;
        logic c1;
        r1 = (r + ONE) < nr;
        c1 = (c + ONE) < nc;
        return {r1 & c1, r1, c1, 1'b1};
    endfunction

    // block offset inside the C region
    function automatic matmul_mem_pkg::addr_t block_offset(
        input matmul_tile_pkg::dim_t r,
        input matmul_tile_pkg::dim_t c,
        input matmul_tile_pkg::dim_t nc
    );
        return matmul_mem_pkg::addr_t'(r) * matmul_mem_pkg::addr_t'(nc)
            + matmul_mem_pkg::addr_t'(c);
    endfunction

    ////////////////////////////////////////////////////////////
    // walk order: inner step, then block column, then block row
    ////////////////////////////////////////////////////////////
    always_comb begin
        last_step   = (k0 + STEP) >= inner;
        col_last    = (col0 + STEP) >= cols;
        row_last    = (row0 + STEP) >= rows;
        final_block = last_step && col_last && row_last;
        nxt_k       = last_step ? '0 : k0 + STEP;
        nxt_col     = last_step ? (col_last ? '0 : col0 + STEP) : col0;
        nxt_row     = (last_step && col_last) ? row0 + STEP : row0;
    end

    // push cycle already reads element 0 of the next tile
    always_comb begin
        if (state == matmul_tile_pkg::FETCH_PUSH) begin
            i_row = nxt_row;
            i_col = nxt_col;
            i_k   = nxt_k;
            i_idx = 2'd0;
        end else begin
            i_row = row0;
            i_col = col0;
            i_k   = k0;
            i_idx = rd_idx;
        end
        a_r = matmul_mem_pkg::addr_t'(i_row) + matmul_mem_pkg::addr_t'(i_idx[1]);
        a_c = matmul_mem_pkg::addr_t'(i_k) + matmul_mem_pkg::addr_t'(i_idx[0]);
        b_r = matmul_mem_pkg::addr_t'(i_k) + matmul_mem_pkg::addr_t'(i_idx[1]);
        b_c = matmul_mem_pkg::addr_t'(i_col) + matmul_mem_pkg::addr_t'(i_idx[0]);
        rd_addr_a = matmul_mem_pkg::region_base(matmul_mem_pkg::REGION_A)
            + a_r * matmul_mem_pkg::addr_t'(inner) + a_c;
        rd_addr_b = matmul_mem_pkg::region_base(matmul_mem_pkg::REGION_B)
            + b_r * matmul_mem_pkg::addr_t'(cols) + b_c;
    end

    // data returning now belongs to the previous read
    assign cap_idx = rd_idx - 2'd1;
    assign a_ok = (row0 + matmul_tile_pkg::dim_t'(cap_idx[1]) < rows)
        && (k0 + matmul_tile_pkg::dim_t'(cap_idx[0]) < inner);
    assign b_ok = (k0 + matmul_tile_pkg::dim_t'(cap_idx[1]) < inner)
        && (col0 + matmul_tile_pkg::dim_t'(cap_idx[0]) < cols);

    assign push = (state == matmul_tile_pkg::FETCH_PUSH) && (credits != '0);

    always_ff @(posedge clk) begin
        if (state == matmul_tile_pkg::FETCH_ISSUE || state == matmul_tile_pkg::FETCH_COLLECT) begin
            a_tile[cap_idx] <= a_ok ? rd_data_a : '0;
            b_tile[cap_idx] <= b_ok ? rd_data_b : '0;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state       <= matmul_tile_pkg::FETCH_IDLE;
            busy        <= 1'b0;
            rd_idx      <= 2'd0;
            row0        <= '0;
            col0        <= '0;
            k0          <= '0;
            tile_mask   <= '0;
            result_addr <= '0;
        end else begin
            case (state)
                matmul_tile_pkg::FETCH_IDLE: begin
                    if (start) begin
                        busy        <= 1'b1;
                        rd_idx      <= 2'd1;
                        tile_mask   <= block_mask('0, '0, rows, cols);
                        result_addr <= '0;
                        state       <= matmul_tile_pkg::FETCH_ISSUE;
                    end
                end
                matmul_tile_pkg::FETCH_ISSUE: begin
                    rd_idx <= rd_idx + 2'd1;
                    if (rd_idx == 2'd3) begin
                        state <= matmul_tile_pkg::FETCH_COLLECT;
                    end
                end
                matmul_tile_pkg::FETCH_COLLECT: begin
                    state <= matmul_tile_pkg::FETCH_PUSH;
                end
                matmul_tile_pkg::FETCH_PUSH: begin
                    if (push && final_block) begin
                        row0  <= '0;
                        col0  <= '0;
                        k0    <= '0;
                        state <= matmul_tile_pkg::FETCH_DRAIN;
                    end else if (push) begin
                        row0   <= nxt_row;
                        col0   <= nxt_col;
                        k0     <= nxt_k;
                        rd_idx <= 2'd1;
                        state  <= matmul_tile_pkg::FETCH_ISSUE;
                        if (last_step) begin
                            tile_mask   <= block_mask(nxt_row, nxt_col, rows, cols);
                            result_addr <= block_offset(nxt_row, nxt_col, cols);
                        end
                    end
                end
                matmul_tile_pkg::FETCH_DRAIN: begin
                    if (done) begin
                        busy  <= 1'b0;
                        state <= matmul_tile_pkg::FETCH_IDLE;
                    end
                end
                default: state <= matmul_tile_pkg::FETCH_IDLE;
            endcase
        end
    end

    // credits track free buffer slots
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            credits <= CRED_W'(`MATMUL_FIFO_DEPTH);
        end else begin
            case ({push, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

//--- rtl/tile_fifo.sv
`include "matmul_config.svh"

module tile_fifo (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            push,
    input  matmul_tile_pkg::data_t [3:0]    a_tile,
    input  matmul_tile_pkg::data_t [3:0]    b_tile,
    input  matmul_tile_pkg::tile_mask_t     tile_mask,
    input  matmul_mem_pkg::addr_t           result_addr,
    input  logic                            last_step,
    input  logic                            final_block,
    input  logic                            pop,
    output logic                            valid,
    output matmul_tile_pkg::data_t [3:0]    head_a_tile,
    output matmul_tile_pkg::data_t [3:0]    head_b_tile,
    output matmul_tile_pkg::tile_mask_t     head_mask,
    output matmul_mem_pkg::addr_t           head_addr,
    output logic                            head_last,
    output logic                            head_final,
    output logic                            credit_return
);
    localparam int DEPTH = `MATMUL_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int ENTRY_W = 8 * `MATMUL_DATA_W + 4 + `MATMUL_ADDR_W + 2;

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic take;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign valid = (count != '0);
    assign take = pop && valid;
    assign credit_return = take;
    assign {head_a_tile, head_b_tile, head_mask, head_addr, head_last, head_final} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {a_tile, b_tile, tile_mask, result_addr, last_step, final_block};
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (take) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, take})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rtl/block_mac.sv
module block_mac (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            valid,
    input  matmul_tile_pkg::data_t [3:0]    a_tile,
    input  matmul_tile_pkg::data_t [3:0]    b_tile,
    input  matmul_tile_pkg::tile_mask_t     tile_mask,
    input  matmul_mem_pkg::addr_t           result_addr,
    input  logic                            last_step,
    input  logic                            final_block,
    input  matmul_tile_pkg::dim_t           cols,
    output logic                            pop,
    output logic                            wr_en,
    output matmul_mem_pkg::addr_t           wr_addr,
    output matmul_tile_pkg::data_t          wr_data,
    output logic                            done
);
    // products indexed {row, col, k}
    matmul_tile_pkg::data_t [7:0] prod;
    matmul_tile_pkg::data_t [3:0] acc;
    matmul_tile_pkg::tile_mask_t wb_mask;
    matmul_mem_pkg::addr_t wb_base;
    logic [1:0] wb_idx;
    logic p_valid, p_last, blk_first, blk_pend, wb_active, wb_final;

    // hold off once a block's last tile is in flight
    assign pop = valid && !blk_pend;

    always_ff @(posedge clk) begin
        if (pop) begin
            for (int e = 0; e < 8; e++) begin
                prod[e] <= a_tile[{e[2], e[0]}] * b_tile[{e[0], e[1]}];
            end
            if (last_step) begin
                wb_mask <= tile_mask;
                wb_base <= matmul_mem_pkg::region_base(matmul_mem_pkg::REGION_C)
                    + result_addr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (p_valid) begin
            for (int e = 0; e < 4; e++) begin
                acc[e] <= (blk_first ? '0 : acc[e]) + prod[2*e] + prod[2*e+1];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // pipeline control and writeback walk
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            p_valid   <= 1'b0;
            p_last    <= 1'b0;
            blk_first <= 1'b1;
            blk_pend  <= 1'b0;
            wb_active <= 1'b0;
            wb_idx    <= 2'd0;
            wb_final  <= 1'b0;
            done      <= 1'b0;
        end else begin
            p_valid <= pop;
            p_last  <= pop && last_step;
            done    <= wb_active && (wb_idx == 2'd3) && wb_final;
            if (pop && last_step) begin
                blk_pend <= 1'b1;
                wb_final <= final_block;
            end
            if (p_valid) begin
                blk_first <= p_last;
            end
            if (p_last) begin
                wb_active <= 1'b1;
                wb_idx    <= 2'd0;
            end else if (wb_active) begin
                wb_idx <= wb_idx + 2'd1;
                if (wb_idx == 2'd3) begin
                    wb_active <= 1'b0;
                    blk_pend  <= 1'b0;
                end
            end
        end
    end

    // lower row sits one matrix row further on
    assign wr_en   = wb_active && wb_mask[wb_idx];
    assign wr_addr = wb_base
        + (wb_idx[1] ? matmul_mem_pkg::addr_t'(cols) : '0)
        + matmul_mem_pkg::addr_t'(wb_idx[0]);
    assign wr_data = acc[wb_idx];

endmodule

//--- rtl/matmul_top.sv
module matmul_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  matmul_tile_pkg::dim_t   rows,
    input  matmul_tile_pkg::dim_t   inner,
    input  matmul_tile_pkg::dim_t   cols,
    output matmul_mem_pkg::addr_t   rd_addr_a,
    input  matmul_tile_pkg::data_t  rd_data_a,
    output matmul_mem_pkg::addr_t   rd_addr_b,
    input  matmul_tile_pkg::data_t  rd_data_b,
    output logic                    wr_en,
    output matmul_mem_pkg::addr_t   wr_addr,
    output matmul_tile_pkg::data_t  wr_data,
    output logic                    busy,
    output logic                    done
);
    // producer to buffer
    logic push, credit_return, last_step, final_block;
    matmul_tile_pkg::data_t [3:0] a_tile, b_tile;
    matmul_tile_pkg::tile_mask_t tile_mask;
    matmul_mem_pkg::addr_t result_addr;

    // buffer to consumer
    logic valid, pop, head_last, head_final;
    matmul_tile_pkg::data_t [3:0] head_a_tile, head_b_tile;
    matmul_tile_pkg::tile_mask_t head_mask;
    matmul_mem_pkg::addr_t head_addr;

    tile_fetch tile_fetch_i (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .rows          (rows),
        .inner         (inner),
        .cols          (cols),
        .credit_return (credit_return),
        .done          (done),
        .rd_data_a     (rd_data_a),
        .rd_data_b     (rd_data_b),
        .busy          (busy),
        .rd_addr_a     (rd_addr_a),
        .rd_addr_b     (rd_addr_b),
        .push          (push),
        .a_tile        (a_tile),
        .b_tile        (b_tile),
        .tile_mask     (tile_mask),
        .result_addr   (result_addr),
        .last_step     (last_step),
        .final_block   (final_block)
    );

    tile_fifo tile_fifo_i (
        .clk           (clk),
        .reset         (reset),
        .push          (push),
        .a_tile        (a_tile),
        .b_tile        (b_tile),
        .tile_mask     (tile_mask),
        .result_addr   (result_addr),
        .last_step     (last_step),
        .final_block   (final_block),
        .pop           (pop),
        .valid         (valid),
        .head_a_tile   (head_a_tile),
        .head_b_tile   (head_b_tile),
        .head_mask     (head_mask),
        .head_addr     (head_addr),
        .head_last     (head_last),
        .head_final    (head_final),
        .credit_return (credit_return)
    );

    block_mac block_mac_i (
        .clk           (clk),
        .reset         (reset),
        .valid         (valid),
        .a_tile        (head_a_tile),
        .b_tile        (head_b_tile),
        .tile_mask     (head_mask),
        .result_addr   (head_addr),
        .last_step     (head_last),
        .final_block   (head_final),
        .cols          (cols),
        .pop           (pop),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .done          (done)
    );

endmodule

//--- testbench/matmul_assert.sv
`include "matmul_config.svh"

module matmul_assert #(
    parameter int LEVEL_W = $clog2(`MATMUL_FIFO_DEPTH + 1)
) (
    input logic               clk,
    input logic               reset,
    input logic [LEVEL_W-1:0] credits,
    input logic [LEVEL_W-1:0] fifo_count,
    input logic               push,
    input logic               done,
    input logic               busy,
    input logic               wr_en
);
    timeunit 1ns;
    timeprecision 1ps;

    credit_bound: assert property (@(posedge clk) disable iff (!reset)
        credits <= LEVEL_W'(`MATMUL_FIFO_DEPTH))
        else $error("credit count above buffer depth");

    // a push at zero credits would land in a full buffer
    push_with_room: assert property (@(posedge clk) disable iff (!reset)
        push |-> fifo_count < LEVEL_W'(`MATMUL_FIFO_DEPTH))
        else $error("push into a full tile buffer");

    // buffer never holds more than its depth
    fifo_bound: assert property (@(posedge clk) disable iff (!reset)
        fifo_count <= LEVEL_W'(`MATMUL_FIFO_DEPTH))
        else $error("tile buffer over its depth");

    done_single: assert property (@(posedge clk) disable iff (!reset)
        done |=> !done)
        else $error("done held longer than one cycle");

    write_while_busy: assert property (@(posedge clk) disable iff (!reset)
        wr_en |-> busy)
        else $error("memory write while not busy");

endmodule

bind matmul_top matmul_assert matmul_assert_i (
    .clk        (clk),
    .reset      (reset),
    .credits    (tile_fetch_i.credits),
    .fifo_count (tile_fifo_i.count),
    .push       (push),
    .done       (done),
    .busy       (busy),
    .wr_en      (wr_en)
);

//--- testbench/matmul_tb.sv
`include "matmul_config.svh"

module matmul_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS = 1 << `MATMUL_ADDR_W;
    localparam int VEC_WORDS = 512;

    logic clk;
    logic reset;
    logic start;
    matmul_tile_pkg::dim_t rows, inner, cols;
    matmul_mem_pkg::addr_t rd_addr_a, rd_addr_b, wr_addr;
    matmul_tile_pkg::data_t rd_data_a = '0;
    matmul_tile_pkg::data_t rd_data_b = '0;
    matmul_tile_pkg::data_t wr_data;
    logic wr_en, busy, done;

    // loader port into the memory model, used only while the DUT is idle
    logic load_en;
    matmul_mem_pkg::addr_t load_addr;
    matmul_tile_pkg::data_t load_data;

    matmul_tile_pkg::data_t mem [0:MEM_WORDS-1];
    matmul_tile_pkg::data_t vec [0:VEC_WORDS-1];

    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int done_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    matmul_top matmul_top_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .rows      (rows),
        .inner     (inner),
        .cols      (cols),
        .rd_addr_a (rd_addr_a),
        .rd_data_a (rd_data_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .busy      (busy),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // two read ports with one cycle latency, one write port
    always @(posedge clk) begin
        rd_data_a <= mem[rd_addr_a];
        rd_data_b <= mem[rd_addr_b];
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    always @(negedge clk) begin
        if (done) begin
            done_count <= done_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: no result after %0d clock cycles", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_value(input string name, input matmul_tile_pkg::data_t expected,
                               input matmul_tile_pkg::data_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic write_word(input int addr, input matmul_tile_pkg::data_t data);
        load_en   = 1'b1;
        load_addr = matmul_mem_pkg::addr_t'(addr);
        load_data = data;
        idle_cycles(1);
    endtask

    ////////////////////////////////////////////////////////////
    // one case: load, start, wait for done, compare C and guards
    ////////////////////////////////////////////////////////////
    task automatic run_case(input int p, input int num, output int next_p);
        int r, n, c, a_pos, b_pos, c_pos, gap, done_before, errs_before;
        matmul_tile_pkg::data_t guard;
        r = int'(vec[p][23:16]);
        n = int'(vec[p][15:8]);
        c = int'(vec[p][7:0]);
        guard = vec[p+1];
        a_pos = p + 2;
        b_pos = a_pos + r * n;
        c_pos = b_pos + n * c;
        next_p = c_pos + r * c;
        errs_before = error_count;
        for (int i = 0; i < r * n; i++) begin
            write_word(`MATMUL_A_BASE + i, vec[a_pos+i]);
        end
        for (int i = 0; i < n * c; i++) begin
            write_word(`MATMUL_B_BASE + i, vec[b_pos+i]);
        end
        // C region and one word on each side start out as guard
        for (int i = -1; i <= r * c; i++) begin
            write_word(`MATMUL_C_BASE + i, guard);
        end
        load_en = 1'b0;
        rows  = matmul_tile_pkg::dim_t'(r);
        inner = matmul_tile_pkg::dim_t'(n);
        cols  = matmul_tile_pkg::dim_t'(c);
        gap = $urandom % 8;
        idle_cycles(gap);
        done_before = done_count;
        check_value("busy before start", 32'd0, 32'(busy));
        start = 1'b1;
        idle_cycles(1);
        start = 1'b0;
        check_value("busy after start", 32'd1, 32'(busy));
        // a start while busy must be ignored
        idle_cycles(2);
        start = 1'b1;
        idle_cycles(1);
        start = 1'b0;
        while (done !== 1'b1) begin
            idle_cycles(1);
        end
        check_value("busy with done", 32'd1, 32'(busy));
        idle_cycles(1);
        check_value("done after pulse", 32'd0, 32'(done));
        check_value("busy after done", 32'd0, 32'(busy));
        for (int i = 0; i < r; i++) begin
            for (int j = 0; j < c; j++) begin
                check_value($sformatf("C[%0d][%0d]", i, j), vec[c_pos+i*c+j],
                            mem[`MATMUL_C_BASE+i*c+j]);
            end
        end
        check_value("guard below C", guard, mem[`MATMUL_C_BASE-1]);
        check_value("guard above C", guard, mem[`MATMUL_C_BASE+r*c]);
        idle_cycles(3);
        check_value("done pulses", 32'd1, 32'(done_count - done_before));
        test_count++;
        $display("test %0d: %0dx%0dx%0d %s", num, r, n, c,
                 (error_count == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int p;
        int num;
        int next_p;
        reset     = 1'b0;
        start     = 1'b0;
        rows      = '0;
        inner     = '0;
        cols      = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(32'h7c49));
        $readmemh("testbench/matmul_vectors.hex", vec);

        // count the cases and size the watchdog
        p = 0;
        num = 0;
        while (p < VEC_WORDS - 1 && !$isunknown(vec[p]) && vec[p] != '0) begin
            cycle_limit += 8 * int'(vec[p][23:16]) * int'(vec[p][15:8])
                * int'(vec[p][7:0]) + 200;
            p = p + 2 + int'(vec[p][23:16]) * int'(vec[p][15:8])
                + int'(vec[p][15:8]) * int'(vec[p][7:0])
                + int'(vec[p][23:16]) * int'(vec[p][7:0]);
            num++;
        end
        if (num == 0) begin
            error_count++;
            $display("no test vectors were loaded");
        end

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b1;
        idle_cycles(1);

        p = 0;
        for (int t = 1; t <= num; t++) begin
            run_case(p, t, next_p);
            p = next_p;
        end

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- testbench/matmul_vectors.hex
// header 00RRIICC gives rows, inner, cols; the next word is the guard value
// then A, B and expected C, each row-major; a zero header ends the list
00020202 a5a50001
00000001 00000002 00000003 00000004
00000005 00000006 00000007 00000008
00000013 00000016 0000002b 00000032
00030503 a5a50002
00000001 00000002 00000003 00000004 00000005
00000000 00000001 00000000 00000001 00000000
00000002 00000000 00000000 00000000 00000001
00000001 00000000 00000002 00000000 00000001 00000001
00000001 00000001 00000000 00000002 00000000 00000001
00000000 00000003 00000001
0000000c 00000014 0000000d 00000002 00000001 00000002 00000002 00000003 00000005
00060408 a5a50003
00000001 00000000 00000000 00000000 00000000 00000001 00000000 00000000
00000001 00000001 00000001 00000001 00000002 00000000 00000000 00000001
00000000 00000000 00000003 00000000 00000001 00000002 00000003 00000004
00000010 00000011 00000012 00000013 00000014 00000015 00000016 00000017
00000020 00000021 00000022 00000023 00000024 00000025 00000026 00000027
00000030 00000031 00000032 00000033 00000034 00000035 00000036 00000037
00000040 00000041 00000042 00000043 00000044 00000045 00000046 00000047
00000010 00000011 00000012 00000013 00000014 00000015 00000016 00000017
00000020 00000021 00000022 00000023 00000024 00000025 00000026 00000027
000000a0 000000a4 000000a8 000000ac 000000b0 000000b4 000000b8 000000bc
00000060 00000063 00000066 00000069 0000006c 0000006f 00000072 00000075
00000090 00000093 00000096 00000099 0000009c 0000009f 000000a2 000000a5
000001e0 000001ea 000001f4 000001fe 00000208 00000212 0000021c 00000226
00020202 a5a50004
80000001 7fffffff 00000003 80000000
80000001 00000002 ffffffff 7fffffff
80000002 00000003 00000003 80000006
00010301 a5a50005
00000002 00000003 00000004
00000005 00000006 00000007
00000038
00000000

//--- files.f
+incdir+rtl
rtl/matmul_tile_pkg.sv
rtl/matmul_mem_pkg.sv
rtl/tile_fetch.sv
rtl/tile_fifo.sv
rtl/block_mac.sv
rtl/matmul_top.sv
testbench/matmul_assert.sv
testbench/matmul_tb.sv

//--- Makefile
TOP       ?= matmul_tb
SEED_ARGS ?= +verilator+seed+1
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator

FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors
SOURCES   := files.f $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: TOP SEED_ARGS LOG OBJ_DIR VERILATOR"

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) --binary --timing --assert -f files.f --top-module $(TOP) -Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test did not finish"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
